// ==== hw/phx_pkg.sv ====
package phx_pkg;

	// ==================================================================
	// Machine sizes
	// ==================================================================

	localparam int NTHREADS   = 4;
	localparam int THREAD_W   = 2;
	localparam int XLEN       = 32;
	localparam int NREGS      = 16;
	localparam int REG_W      = 4;
	localparam int IMEM_DEPTH = 64;
	localparam int IADDR_W    = 6;
	localparam int IMM_W      = 16;
	// Word spacing between thread start addresses
	localparam int RST_STRIDE = 16;

	typedef logic [THREAD_W-1:0] thread_t;
	typedef logic [REG_W-1:0]    reg_idx_t;
	typedef logic [XLEN-1:0]     word_t;
	typedef logic [IADDR_W-1:0]  iaddr_t;

	// ==================================================================
	// Instruction set
	// ==================================================================

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_ADDI = 4'h6,
		OP_BEQ  = 4'h7,
		OP_BNE  = 4'h8,
		OP_JAL  = 4'h9,
		OP_HALT = 4'hA
	} opcode_e;

	// Opcode, rd and ra sit at the same bits in both formats
	typedef union packed {
		// Register form for the ALU operations
		struct packed {
			opcode_e         opcode;
			reg_idx_t        rd;
			reg_idx_t        ra;
			reg_idx_t        rb;
			logic [IMM_W-1:0] pad;
		} r_form;
		// Immediate form for ADDI, branches and JAL
		struct packed {
			opcode_e         opcode;
			reg_idx_t        rd;
			reg_idx_t        ra;
			logic [3:0]      pad;
			logic [IMM_W-1:0] imm;
		} i_form;
	} insn_t;

	// Start address of a thread after reset
	function automatic iaddr_t rst_ip(thread_t thr);
		return iaddr_t'(int'(thr) * RST_STRIDE);
	endfunction

endpackage

// ==== hw/phx_ifs.sv ====
`timescale 1ns/1ps

// Fetch to decode, one instruction word per strobe
interface fetch_if;
	import phx_pkg::*;

	logic    valid;
	thread_t thread;
	iaddr_t  ip;
	insn_t   insn;

	modport source (output valid, thread, ip, insn);
	modport sink   (input  valid, thread, ip, insn);
endinterface

// Decode to execute, instruction plus both operands
interface issue_if;
	import phx_pkg::*;

	logic    valid;
	thread_t thread;
	iaddr_t  ip;
	insn_t   insn;
	word_t   opa;
	word_t   opb;

	modport source (output valid, thread, ip, insn, opa, opb);
	modport sink   (input  valid, thread, ip, insn, opa, opb);
endinterface

// Execute result toward fetch and the register banks
interface wb_if;
	import phx_pkg::*;

	logic     valid;
	thread_t  thread;
	reg_idx_t rd;
	logic     wr;
	word_t    data;
	iaddr_t   next_ip;
	logic     halt;

	modport source (output valid, thread, rd, wr, data, next_ip, halt);
	modport sink   (input  valid, thread, rd, wr, data, next_ip, halt);
endinterface

// ==== hw/phx_fetch.sv ====
`timescale 1ns/1ps

module phx_fetch (
	input  logic                      clk_g,
	input  logic                      rst_i,
	input  logic                      run_i,
	input  logic                      imem_we_i,
	input  phx_pkg::iaddr_t           imem_addr_i,
	input  phx_pkg::insn_t            imem_data_i,
	wb_if.sink                        wb,
	fetch_if.source                   fet,
	output logic [phx_pkg::NTHREADS-1:0] halted_o
);
	import phx_pkg::*;

	// ==================================================================
	// Per-thread state
	// ==================================================================

	iaddr_t              ip_q [NTHREADS];
	logic [NTHREADS-1:0] busy_q;
	logic [NTHREADS-1:0] halted_q;
	thread_t             rr_q;

	insn_t               imem [IMEM_DEPTH];

	// Selection stage, one cycle ahead of the memory read
	logic                sel_vld_q;
	thread_t             sel_thr_q;
	iaddr_t              sel_ip_q;

	logic [NTHREADS-1:0] wb_free;
	logic [NTHREADS-1:0] avail;
	logic                pick_vld;
	thread_t             pick_thr;
	thread_t             cand;
	iaddr_t              pick_ip;

	// A thread retiring this cycle is free again unless it halts
	always_comb begin
		for (int t = 0; t < NTHREADS; t++) begin
			wb_free[t] = wb.valid && (wb.thread == thread_t'(t)) && !wb.halt;
			avail[t]   = run_i && !halted_q[t] && (!busy_q[t] || wb_free[t]);
		end
	end

	// Round robin, first free thread at or after the pointer
	always_comb begin
		pick_vld = 1'b0;
		pick_thr = rr_q;
		cand     = rr_q;
		for (int i = 0; i < NTHREADS; i++) begin
			cand = rr_q + thread_t'(i);
			if (!pick_vld && avail[cand]) begin
				pick_vld = 1'b1;
				pick_thr = cand;
			end
		end
	end

	// Bypass the ip of a thread retiring right now
	assign pick_ip = wb_free[pick_thr] ? wb.next_ip : ip_q[pick_thr];

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int t = 0; t < NTHREADS; t++)
				ip_q[t] <= rst_ip(thread_t'(t));
			busy_q    <= '0;
			halted_q  <= '0;
			rr_q      <= '0;
			sel_vld_q <= 1'b0;
		end else begin
			// Retire first so that a new pick wins the busy bit
			if (wb.valid) begin
				ip_q[wb.thread]   <= wb.next_ip;
				busy_q[wb.thread] <= 1'b0;
				if (wb.halt)
					halted_q[wb.thread] <= 1'b1;
			end
			if (pick_vld) begin
				busy_q[pick_thr] <= 1'b1;
				rr_q             <= pick_thr + 1'b1;
			end
			sel_vld_q <= pick_vld;
		end
	end

	always_ff @(posedge clk_g) begin
		sel_thr_q <= pick_thr;
		sel_ip_q  <= pick_ip;
	end

	// ==================================================================
	// Instruction memory, loaded from the top while stopped
	// ==================================================================

	always_ff @(posedge clk_g) begin
		if (imem_we_i)
			imem[imem_addr_i] <= imem_data_i;
		fet.insn   <= imem[sel_ip_q];
		fet.thread <= sel_thr_q;
		fet.ip     <= sel_ip_q;
	end

	always_ff @(posedge clk_g) begin
		if (rst_i)
			fet.valid <= 1'b0;
		else
			fet.valid <= sel_vld_q;
	end

	assign halted_o = halted_q;

	// Picked thread is live and has nothing in the front stages
	a_pick_free: assert property (@(posedge clk_g) disable iff (rst_i)
		pick_vld |-> !halted_q[pick_thr] && (!busy_q[pick_thr] || wb_free[pick_thr])
			&& !(sel_vld_q && sel_thr_q == pick_thr)
			&& !(fet.valid && fet.thread == pick_thr))
		else $error("fetch picked a thread that is still in flight");

	// Execute only retires threads that were issued
	a_wb_busy: assert property (@(posedge clk_g) disable iff (rst_i)
		wb.valid |-> busy_q[wb.thread])
		else $error("writeback for a thread that is not busy");

endmodule

// ==== hw/phx_regfile.sv ====
`timescale 1ns/1ps

module phx_regfile (
	input  logic              clk_g,
	input  logic              rst_i,
	input  phx_pkg::thread_t  rd_thread_i,
	input  phx_pkg::reg_idx_t ra_i,
	input  phx_pkg::reg_idx_t rb_i,
	output phx_pkg::word_t    ra_data_o,
	output phx_pkg::word_t    rb_data_o,
	wb_if.sink                wb
);
	import phx_pkg::*;

	// One bank per thread, addressed by {thread, reg}
	word_t                        bank [NTHREADS*NREGS];
	// Written flags, so that every bank reads zero after reset
	logic [NTHREADS*NREGS-1:0]    vld_q;

	// R0 and never written entries read as zero
	function automatic word_t rd_port(thread_t thr, reg_idx_t idx);
		logic [THREAD_W+REG_W-1:0] a;
		a = {thr, idx};
		if (idx == '0 || !vld_q[a])
			return '0;
		return bank[a];
	endfunction

	always_comb begin
		ra_data_o = rd_port(rd_thread_i, ra_i);
		rb_data_o = rd_port(rd_thread_i, rb_i);
	end

	always_ff @(posedge clk_g) begin
		if (rst_i)
			vld_q <= '0;
		else if (wb.valid && wb.wr)
			vld_q[{wb.thread, wb.rd}] <= 1'b1;
	end

	always_ff @(posedge clk_g) begin
		if (wb.valid && wb.wr)
			bank[{wb.thread, wb.rd}] <= wb.data;
	end

	// Execute drops the write for rd == 0
	a_no_r0_write: assert property (@(posedge clk_g) disable iff (rst_i)
		wb.valid && wb.wr |-> wb.rd != '0)
		else $error("register write to r0");

endmodule

// ==== hw/phx_decode.sv ====
`timescale 1ns/1ps

module phx_decode (
	input  logic              clk_g,
	input  logic              rst_i,
	fetch_if.sink             fet,
	output phx_pkg::thread_t  rf_thread_o,
	output phx_pkg::reg_idx_t rf_ra_o,
	output phx_pkg::reg_idx_t rf_rb_o,
	input  phx_pkg::word_t    rf_ra_data_i,
	input  phx_pkg::word_t    rf_rb_data_i,
	issue_if.source           iss
);
	import phx_pkg::*;

	insn_t    insn_c;
	reg_idx_t ra_c;
	reg_idx_t rb_c;

	// ==================================================================
	// Operand selection
	// ==================================================================

	always_comb begin
		insn_c = fet.insn;
		ra_c   = '0;
		rb_c   = '0;
		case (fet.insn.r_form.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
				ra_c = fet.insn.r_form.ra;
				rb_c = fet.insn.r_form.rb;
			end
			OP_ADDI: begin
				ra_c = fet.insn.i_form.ra;
			end
			// Branches compare ra with the register named in rd
			OP_BEQ, OP_BNE: begin
				ra_c = fet.insn.i_form.ra;
				rb_c = fet.insn.i_form.rd;
			end
			// No register reads, rd and target come from i_form
			OP_JAL, OP_HALT, OP_NOP: begin
			end
			default: begin
				// Unknown words retire as NOP
				insn_c.r_form.opcode = OP_NOP;
			end
		endcase
	end

	assign rf_thread_o = fet.thread;
	assign rf_ra_o     = ra_c;
	assign rf_rb_o     = rb_c;

	// ==================================================================
	// Issue register
	// ==================================================================

	always_ff @(posedge clk_g) begin
		if (rst_i)
			iss.valid <= 1'b0;
		else
			iss.valid <= fet.valid;
	end

	always_ff @(posedge clk_g) begin
		iss.thread <= fet.thread;
		iss.ip     <= fet.ip;
		iss.insn   <= insn_c;
		iss.opa    <= rf_ra_data_i;
		iss.opb    <= rf_rb_data_i;
	end

endmodule

// ==== hw/phx_execute.sv ====
`timescale 1ns/1ps

module phx_execute (
	input  logic    clk_g,
	input  logic    rst_i,
	issue_if.sink   iss,
	wb_if.source    wb
);
	import phx_pkg::*;

	word_t    imm_x;
	iaddr_t   ip_inc;
	word_t    res_c;
	iaddr_t   nip_c;
	reg_idx_t rd_c;
	logic     writes_c;
	logic     halt_c;

	// Sign extended immediate and fall-through address
	assign imm_x  = {{(XLEN-IMM_W){iss.insn.i_form.imm[IMM_W-1]}}, iss.insn.i_form.imm};
	assign ip_inc = iss.ip + 1'b1;

	// ==================================================================
	// ALU and next ip
	// ==================================================================

	always_comb begin
		res_c    = '0;
		nip_c    = ip_inc;
		rd_c     = iss.insn.r_form.rd;
		writes_c = 1'b0;
		halt_c   = 1'b0;
		case (iss.insn.r_form.opcode)
			OP_ADD: begin
				res_c    = iss.opa + iss.opb;
				writes_c = 1'b1;
			end
			OP_SUB: begin
				res_c    = iss.opa - iss.opb;
				writes_c = 1'b1;
			end
			OP_AND: begin
				res_c    = iss.opa & iss.opb;
				writes_c = 1'b1;
			end
			OP_OR: begin
				res_c    = iss.opa | iss.opb;
				writes_c = 1'b1;
			end
			OP_XOR: begin
				res_c    = iss.opa ^ iss.opb;
				writes_c = 1'b1;
			end
			OP_ADDI: begin
				res_c    = iss.opa + imm_x;
				writes_c = 1'b1;
			end
			// Relative targets wrap around the memory
			OP_BEQ: begin
				if (iss.opa == iss.opb)
					nip_c = iss.ip + iss.insn.i_form.imm[IADDR_W-1:0];
			end
			OP_BNE: begin
				if (iss.opa != iss.opb)
					nip_c = iss.ip + iss.insn.i_form.imm[IADDR_W-1:0];
			end
			// Absolute target with ip+1 as the link
			OP_JAL: begin
				nip_c    = iss.insn.i_form.imm[IADDR_W-1:0];
				res_c    = word_t'(ip_inc);
				writes_c = 1'b1;
			end
			// Thread parks on its own address
			OP_HALT: begin
				nip_c  = iss.ip;
				halt_c = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// ==================================================================
	// Writeback register
	// ==================================================================

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			wb.valid <= 1'b0;
			wb.wr    <= 1'b0;
			wb.halt  <= 1'b0;
		end else begin
			wb.valid <= iss.valid;
			wb.wr    <= iss.valid && writes_c && (rd_c != '0);
			wb.halt  <= iss.valid && halt_c;
		end
	end

	always_ff @(posedge clk_g) begin
		wb.thread  <= iss.thread;
		wb.rd      <= rd_c;
		wb.data    <= res_c;
		wb.next_ip <= nip_c;
	end

	// One instruction per thread between issue and writeback
	a_thread_once: assert property (@(posedge clk_g) disable iff (rst_i)
		iss.valid && wb.valid |-> iss.thread != wb.thread)
		else $error("same thread in issue and writeback");

endmodule

// ==== hw/phx_core.sv ====
`timescale 1ns/1ps

module phx_core (
	input  logic                         clk_g,
	input  logic                         rst_i,
	input  logic                         run_i,
	input  logic                         imem_we_i,
	input  phx_pkg::iaddr_t              imem_addr_i,
	input  phx_pkg::insn_t               imem_data_i,
	output logic                         commit_valid_o,
	output phx_pkg::thread_t             commit_thread_o,
	output phx_pkg::reg_idx_t            commit_rd_o,
	output phx_pkg::word_t               commit_data_o,
	output logic [phx_pkg::NTHREADS-1:0] halted_o
);

	// ==================================================================
	// Stage buses
	// ==================================================================

	fetch_if i_fet_if ();
	issue_if i_iss_if ();
	wb_if    i_wb_if ();

	// Decode to register bank read port
	phx_pkg::thread_t  rf_thread;
	phx_pkg::reg_idx_t rf_ra;
	phx_pkg::reg_idx_t rf_rb;
	phx_pkg::word_t    rf_ra_data;
	phx_pkg::word_t    rf_rb_data;

	phx_fetch i_fetch (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.run_i       (run_i),
		.imem_we_i   (imem_we_i),
		.imem_addr_i (imem_addr_i),
		.imem_data_i (imem_data_i),
		.wb          (i_wb_if.sink),
		.fet         (i_fet_if.source),
		.halted_o    (halted_o)
	);

	phx_decode i_decode (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.fet          (i_fet_if.sink),
		.rf_thread_o  (rf_thread),
		.rf_ra_o      (rf_ra),
		.rf_rb_o      (rf_rb),
		.rf_ra_data_i (rf_ra_data),
		.rf_rb_data_i (rf_rb_data),
		.iss          (i_iss_if.source)
	);

	phx_regfile i_regfile (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.rd_thread_i (rf_thread),
		.ra_i        (rf_ra),
		.rb_i        (rf_rb),
		.ra_data_o   (rf_ra_data),
		.rb_data_o   (rf_rb_data),
		.wb          (i_wb_if.sink)
	);

	phx_execute i_execute (
		.clk_g (clk_g),
		.rst_i (rst_i),
		.iss   (i_iss_if.sink),
		.wb    (i_wb_if.source)
	);

	// Commit port shows only real register writes
	assign commit_valid_o  = i_wb_if.valid && i_wb_if.wr;
	assign commit_thread_o = commit_valid_o ? i_wb_if.thread : '0;
	assign commit_rd_o     = commit_valid_o ? i_wb_if.rd : '0;
	assign commit_data_o   = commit_valid_o ? i_wb_if.data : '0;

endmodule

// ==== dv/tb_phx_core.sv ====
`timescale 1ns/1ps

module tb_phx_core;
	import phx_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int WD_MARGIN  = 2000;
	localparam int HALT_WAIT  = 64;
	localparam int QUIET_CYC  = 20;

	logic                clk_g = 1'b0;
	logic                rst_i;
	logic                run_i;
	logic                imem_we_i;
	iaddr_t              imem_addr_i;
	insn_t               imem_data_i;
	logic                commit_valid_o;
	thread_t             commit_thread_o;
	reg_idx_t            commit_rd_o;
	word_t               commit_data_o;
	logic [NTHREADS-1:0] halted_o;

	// Program image and expected commits from the golden file
	iaddr_t   prog_addr [$];
	insn_t    prog_word [$];
	thread_t  exp_thr [$];
	reg_idx_t exp_rd [$];
	word_t    exp_data [$];
	int       n_prog;
	int       n_exp;
	int       n_seen;
	int       next_pos [NTHREADS];
	logic     golden_ready = 1'b0;
	logic [31:0] rng;

	phx_core i_dut (
		.clk_g           (clk_g),
		.rst_i           (rst_i),
		.run_i           (run_i),
		.imem_we_i       (imem_we_i),
		.imem_addr_i     (imem_addr_i),
		.imem_data_i     (imem_data_i),
		.commit_valid_o  (commit_valid_o),
		.commit_thread_o (commit_thread_o),
		.commit_rd_o     (commit_rd_o),
		.commit_data_o   (commit_data_o),
		.halted_o        (halted_o)
	);

	always #(CLK_PERIOD/2) clk_g = ~clk_g;

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Index of the next expected commit of one thread or -1 when none is left
	function automatic int next_expected(thread_t thr, int from);
		int found;
		found = -1;
		for (int i = from; i < exp_thr.size(); i++)
			if (found < 0 && exp_thr[i] == thr)
				found = i;
		return found;
	endfunction

	task automatic check_commit(thread_t thr, reg_idx_t rd, word_t data);
		int idx;
		idx = next_expected(thr, next_pos[thr]);
		if (idx < 0) begin
			$display("Thread %0d committed r%0d at %0t with no commit left to expect",
				thr, rd, $time);
			abort_run();
		end else if (rd !== exp_rd[idx]) begin
			$display("[ERROR] %0t commit_rd_o (thread %0d): expected %0d, got %0d",
				$time, thr, exp_rd[idx], rd);
			abort_run();
		end else if (data !== exp_data[idx]) begin
			$display("[ERROR] %0t commit_data_o (thread %0d r%0d): expected %h, got %h",
				$time, thr, rd, exp_data[idx], data);
			abort_run();
		end else begin
			next_pos[thr] = idx + 1;
			n_seen++;
		end
	endtask

	task automatic check_halted(logic [NTHREADS-1:0] got, logic [NTHREADS-1:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0t halted_o: expected %b, got %b", $time, expected, got);
			abort_run();
		end
	endtask

	// Lines are "I addr word", "E thread rd data" or "# comment"
	task automatic read_golden();
		int          fd;
		int          code;
		int          a;
		int          t;
		int          r;
		word_t       w;
		logic [7:0]  tag;
		logic [959:0] rest;
		logic        bad_line;
		bad_line = 1'b0;
		fd = $fopen("dv/phx_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file dv/phx_golden.txt");
			abort_run();
		end else begin
			code = $fscanf(fd, "%s", tag);
			while (code == 1 && !bad_line) begin
				if (tag == "I") begin
					code = $fscanf(fd, "%h %h", a, w);
					if (code != 2)
						bad_line = 1'b1;
					prog_addr.push_back(iaddr_t'(a));
					prog_word.push_back(insn_t'(w));
				end else if (tag == "E") begin
					code = $fscanf(fd, "%d %d %h", t, r, w);
					if (code != 3)
						bad_line = 1'b1;
					exp_thr.push_back(thread_t'(t));
					exp_rd.push_back(reg_idx_t'(r));
					exp_data.push_back(w);
				end else if (tag == "#") begin
					code = $fgets(rest, fd);
				end else begin
					bad_line = 1'b1;
				end
				if (!bad_line)
					code = $fscanf(fd, "%s", tag);
			end
			$fclose(fd);
			n_prog = prog_addr.size();
			n_exp  = exp_thr.size();
			if (bad_line || n_prog == 0 || n_exp == 0) begin
				$display("The golden file has a malformed line or is missing entries");
				abort_run();
			end else begin
				golden_ready = 1'b1;
			end
		end
	endtask

	// ======================================================================
	// Commit monitor and watchdog
	// ======================================================================

	// Outputs change on the rising edge, so look at them on the falling one
	always @(negedge clk_g) begin
		if (golden_ready && !rst_i && commit_valid_o)
			check_commit(commit_thread_o, commit_rd_o, commit_data_o);
	end

	initial begin : watchdog
		int limit_ns;
		wait (golden_ready);
		limit_ns = 4 * n_prog * n_exp * CLK_PERIOD + WD_MARGIN;
		#(limit_ns);
		$display("The run timed out after %0d ns before all threads finished", limit_ns);
		abort_run();
	end

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin : main_seq
		insn_t img [IMEM_DEPTH];
		int    waited;
		$timeformat(-9, 0, " ns", 0);
		rst_i       = 1'b1;
		run_i       = 1'b0;
		imem_we_i   = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;
		n_seen      = 0;
		rng         = 32'd48813;
		for (int t = 0; t < NTHREADS; t++)
			next_pos[t] = 0;
		read_golden();

		// Unused words hold HALT tagged with their own address
		for (int i = 0; i < IMEM_DEPTH; i++)
			img[i] = insn_t'({OP_HALT, 22'h0, iaddr_t'(i)});
		for (int i = 0; i < n_prog; i++)
			img[prog_addr[i]] = prog_word[i];

		repeat (3) @(posedge clk_g);
		#1;
		rst_i = 1'b0;

		// Load the whole memory while the threads are stopped
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			imem_we_i   = 1'b1;
			imem_addr_i = iaddr_t'(i);
			imem_data_i = img[i];
			@(posedge clk_g);
			#1;
		end
		imem_we_i = 1'b0;
		run_i     = 1'b1;

		// Run with random stalls of zero to three cycles
		while (n_seen < n_exp) begin
			@(posedge clk_g);
			#1;
			rng = xorshift32(rng);
			if (rng[2:0] == 3'd0) begin
				run_i = 1'b0;
				repeat (rng[4:3]) @(posedge clk_g);
				#1;
				run_i = 1'b1;
			end
		end

		// Each thread still has its HALT in flight
		waited = 0;
		while (halted_o !== {NTHREADS{1'b1}} && waited < HALT_WAIT) begin
			@(posedge clk_g);
			#1;
			waited++;
		end
		check_halted(halted_o, {NTHREADS{1'b1}});

		// Any commit in this window trips the monitor
		repeat (QUIET_CYC) @(posedge clk_g);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== dv/phx_golden.txt ====
# I <addr hex> <insn hex> : program word
# E <thread dec> <rd dec> <data hex> : expected commit, in order per thread
# Thread 0 at 0x00, ALU operations and a negative immediate
I 00 6100000C
I 01 6200FFFD
I 02 13120000
I 03 24120000
I 04 35120000
I 05 46120000
I 06 57120000
I 07 A0000000
# Thread 1 at 0x10, writes to r0 are dropped and r0 reads zero
I 10 60000007
I 11 61000004
I 12 12010000
I 13 23010000
I 14 A0000000
# Thread 2 at 0x20, BEQ and BNE taken and not taken
I 20 61000001
I 21 62000001
I 22 72100002
I 23 63000099
I 24 82100002
I 25 64000011
I 26 84100002
I 27 65000055
I 28 74100002
I 29 66000022
I 2A A0000000
# Thread 3 at 0x30, JAL with link and JAL to r0
I 30 97000033
I 31 61000077
I 32 A0000000
I 33 61700001
I 34 90000036
I 35 62000066
I 36 12100000
I 37 A0000000
E 0 1 0000000C
E 0 2 FFFFFFFD
E 0 3 00000009
E 0 4 0000000F
E 0 5 0000000C
E 0 6 FFFFFFFD
E 0 7 FFFFFFF1
E 1 1 00000004
E 1 2 00000004
E 1 3 FFFFFFFC
E 2 1 00000001
E 2 2 00000001
E 2 4 00000011
E 2 6 00000022
E 3 7 00000031
E 3 1 00000032
E 3 2 00000032

// ==== build.f ====
hw/phx_pkg.sv
hw/phx_ifs.sv
hw/phx_fetch.sv
hw/phx_regfile.sv
hw/phx_decode.sv
hw/phx_execute.sv
hw/phx_core.sv
dv/tb_phx_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_phx_core -Mdir obj_dir -o tb_phx_core
out=$(./obj_dir/tb_phx_core 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
